/* logic/serial_cfg_pkg.sv */
package serial_cfg_pkg;

  // block geometry for the output stage.

  // samples per parallel block.
  localparam int n_samples = 8;

  // width of one sample word.
  localparam int sample_w = 16;

  // beat index width, enough for n_samples - 1.
  localparam int index_w = $clog2(n_samples);

endpackage

/* logic/serial_types_pkg.sv */
package serial_types_pkg;

  import serial_cfg_pkg::*;

  // one sample word as it moves through the stage.
  typedef logic [sample_w-1:0] sample_t;

  // a whole block, element 0 sits at the low end.
  typedef sample_t [n_samples-1:0] block_t;

  // one output beat on the send side.
  typedef struct packed {
    sample_t              data;   // selected sample.
    logic [index_w-1:0]   index;  // position inside the block.
    logic                 last;   // set on the final beat of a block.
  } beat_t;

endpackage

/* logic/serializer_control.sv */
module serializer_control (
  input  logic clk,
  input  logic reset,

  // receive handshake.
  input  logic recv_val,
  output logic recv_rdy,

  // send handshake.
  input  logic send_rdy,
  output logic send_val,

  // from the beat counter.
  input  logic last,

  // to bank and counter.
  output logic capture,
  output logic advance,
  output logic clear
);

  typedef enum logic {
    idle,
    sending
  } state_t;

  state_t state;
  state_t next_state;
  logic   last_accept;

  // the final beat of the current block leaves at this edge.
  assign last_accept = (state == sending) && last && send_rdy;

  // a new block may come in while idle or together with the last beat.
  always_comb begin
    recv_rdy = 1'b0;
    send_val = 1'b0;
    case (state)
      idle: begin
        recv_rdy = 1'b1;
      end
      sending: begin
        send_val = 1'b1;
        recv_rdy = last_accept;
      end
      default: begin
        recv_rdy = 1'b0;
        send_val = 1'b0;
      end
    endcase
  end

  assign capture = recv_val && recv_rdy;
  assign advance = send_val && send_rdy;
  assign clear   = capture;  // new block restarts at index 0.

  always_comb begin
    next_state = state;
    case (state)
      idle: begin
        if (capture) begin
          next_state = sending;
        end
      end
      sending: begin
        // stay busy when the next block lands on the last beat.
        if (last_accept && !capture) begin
          next_state = idle;
        end
      end
      default: begin
        next_state = idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

endmodule

/* logic/sample_counter.sv */
module sample_counter (
  input  logic                             clk,
  input  logic                             reset,

  input  logic                             advance,  // beat accepted.
  input  logic                             clear,    // block captured.

  output logic [serial_cfg_pkg::index_w-1:0] index,
  output logic                             last
);

  import serial_cfg_pkg::*;

  localparam logic [index_w-1:0] last_index = index_w'(n_samples - 1);

  // end of block is decided here and nowhere else.
  assign last = (index == last_index);

  always_ff @(posedge clk) begin
    if (reset) begin
      index <= '0;
    end else if (clear) begin
      index <= '0;  // wins over advance on a back to back capture.
    end else if (advance) begin
      if (last) begin
        index <= '0;
      end else begin
        index <= index + 1'b1;
      end
    end
  end

endmodule

/* logic/sample_bank.sv */
module sample_bank (
  input  logic                               clk,
  input  logic                               reset,

  // block load.
  input  logic                               capture,
  input  serial_types_pkg::block_t           block_in,

  // read side.
  input  logic [serial_cfg_pkg::index_w-1:0] index,
  output serial_types_pkg::sample_t          data
);

  import serial_types_pkg::*;

  block_t stored;

  // the whole block is taken in one edge.
  always_ff @(posedge clk) begin
    if (reset) begin
      stored <= '0;
    end else if (capture) begin
      stored <= block_in;
    end
  end

  // read mux over the stored samples.
  assign data = stored[index];

endmodule

/* logic/block_serializer.sv */
module block_serializer (
  input  logic                      clk,
  input  logic                      reset,

  // parallel block in.
  input  serial_types_pkg::block_t  recv_msg,
  input  logic                      recv_val,
  output logic                      recv_rdy,

  // one beat out per transfer.
  output serial_types_pkg::beat_t   send_msg,
  output logic                      send_val,
  input  logic                      send_rdy
);

  import serial_cfg_pkg::*;
  import serial_types_pkg::*;

  logic               capture;
  logic               advance;
  logic               clear;
  logic [index_w-1:0] index;
  logic               last;
  sample_t            data;

  serializer_control i_control (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_rdy (send_rdy),
    .send_val (send_val),
    .last     (last),
    .capture  (capture),
    .advance  (advance),
    .clear    (clear)
  );

  sample_counter i_counter (
    .clk     (clk),
    .reset   (reset),
    .advance (advance),
    .clear   (clear),
    .index   (index),
    .last    (last)
  );

  sample_bank i_bank (
    .clk      (clk),
    .reset    (reset),
    .capture  (capture),
    .block_in (recv_msg),
    .index    (index),
    .data     (data)
  );

  // beat fields.
  assign send_msg.data  = data;
  assign send_msg.index = index;
  assign send_msg.last  = last;

endmodule

/* testbench/serializer_properties.sv */
module serializer_properties (
  input logic                    clk,
  input logic                    reset,
  input serial_types_pkg::beat_t send_msg,
  input logic                    send_val,
  input logic                    send_rdy,
  input logic                    recv_rdy
);
  timeunit 1ns;
  timeprecision 1ps;

  // a stalled beat keeps its valid and its payload until it is taken.
  property send_held_while_stalled;
    @(posedge clk) disable iff (reset)
      (send_val && !send_rdy) |=> (send_val && $stable(send_msg));
  endproperty

  // input side only opens during sending when the last beat leaves.
  property recv_blocked_while_sending;
    @(posedge clk) disable iff (reset)
      (send_val && recv_rdy) |-> (send_msg.last && send_rdy);
  endproperty

  property quiet_in_reset;
    @(posedge clk) (reset && $past(reset)) |-> !send_val;
  endproperty

  a_send_held: assert property (send_held_while_stalled)
    else $error("send side changed while stalled");
  a_recv_blocked: assert property (recv_blocked_while_sending)
    else $error("recv_rdy high in the middle of a block");
  a_reset_quiet: assert property (quiet_in_reset)
    else $error("send_val high during reset");

endmodule

/* testbench/serializer_checker.sv */
module serializer_checker (
  input  logic                     clk,
  input  logic                     reset,
  input  serial_types_pkg::block_t recv_msg,
  input  logic                     recv_val,
  input  logic                     recv_rdy,
  input  serial_types_pkg::beat_t  send_msg,
  input  logic                     send_val,
  input  logic                     send_rdy,
  output int                       error_count,
  output int                       beat_count,
  output int                       block_count
);
  timeunit 1ns;
  timeprecision 1ps;

  import serial_cfg_pkg::*;
  import serial_types_pkg::*;

  block_t  pending[$];  // accepted blocks not yet fully sent.
  int      next_index;
  logic    was_stalled;
  beat_t   held_msg;
  logic    busy;
  logic    expect_rdy;
  sample_t want_data;

  task automatic report_mismatch(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
    $display("CHECK FAILED t=%0t %s expected %0h got %0h", $time, name, want, got);
    error_count++;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      pending.delete();
      next_index  = 0;
      was_stalled = 1'b0;
      error_count = 0;
      beat_count  = 0;
      block_count = 0;
    end else begin
      // reference model of both handshakes from the blocks seen so far.
      busy       = (pending.size() != 0);
      expect_rdy = !busy || ((next_index == n_samples - 1) && send_rdy);
      if (send_val !== busy) report_mismatch("send_val", busy, send_val);
      if (recv_rdy !== expect_rdy) report_mismatch("recv_rdy", expect_rdy, recv_rdy);
      if (was_stalled && (send_msg !== held_msg)) begin
        report_mismatch("send_msg", held_msg, send_msg);  // changed under stall.
      end
      if (send_val && send_rdy) begin
        beat_count++;  // every beat taken on the send side.
        if (!busy) begin
          $display("t=%0t a beat was accepted while no block was pending", $time);
          error_count++;
        end else begin
          want_data = pending[0][next_index];
          if (send_msg.data !== want_data) begin
            report_mismatch("send_msg.data", want_data, send_msg.data);
          end
          if (send_msg.index !== next_index[index_w-1:0]) begin
            report_mismatch("send_msg.index", next_index, send_msg.index);
          end
          if (send_msg.last !== (next_index == n_samples - 1)) begin
            report_mismatch("send_msg.last", next_index == n_samples - 1, send_msg.last);
          end
          if (next_index == n_samples - 1) begin
            void'(pending.pop_front());
            block_count++;
            next_index = 0;
          end else begin
            next_index++;
          end
        end
      end
      if (recv_val && recv_rdy) pending.push_back(recv_msg);  // after the beat.
      was_stalled = send_val && !send_rdy;
      held_msg    = send_msg;
    end
  end

endmodule

/* testbench/block_serializer_tb.sv */
module block_serializer_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import serial_cfg_pkg::*;
  import serial_types_pkg::*;

  localparam int n_tests     = 6;
  localparam int wait_limit  = 200;
  localparam int drain_limit = 400;

  typedef struct packed {
    logic [7:0] blocks;
    logic       rand_fill;
    logic [7:0] stall_mask;  // bit i gives send_rdy in cycle i mod 8.
    logic [3:0] gap;         // idle cycles on recv_val between blocks.
    logic       poke;        // scramble recv_msg while it is blocked.
  } test_row_t;

  logic      clk;
  logic      reset;
  block_t    recv_msg;
  logic      recv_val;
  logic      recv_rdy;
  beat_t     send_msg;
  logic      send_val;
  logic      send_rdy;

  test_row_t table_rows [n_tests];
  test_row_t row;
  logic [7:0] stall_mask;
  int        cycle_no;
  int        seed;
  int        tb_errors;
  int        check_errors;
  int        beats_seen;
  int        blocks_seen;

  block_serializer i_dut (
    .clk      (clk),
    .reset    (reset),
    .recv_msg (recv_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_msg (send_msg),
    .send_val (send_val),
    .send_rdy (send_rdy)
  );

  serializer_checker i_checker (
    .clk         (clk),
    .reset       (reset),
    .recv_msg    (recv_msg),
    .recv_val    (recv_val),
    .recv_rdy    (recv_rdy),
    .send_msg    (send_msg),
    .send_val    (send_val),
    .send_rdy    (send_rdy),
    .error_count (check_errors),
    .beat_count  (beats_seen),
    .block_count (blocks_seen)
  );

  bind block_serializer serializer_properties i_properties (
    .clk      (clk),
    .reset    (reset),
    .send_msg (send_msg),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .recv_rdy (recv_rdy)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // sink side follows the stall mask of the running test.
  always @(posedge clk) begin
    #1;
    send_rdy = stall_mask[cycle_no[2:0]];
    cycle_no = cycle_no + 1;
  end

  task automatic fill_block(input logic rand_fill, input int test, input int blk);
    int i;
    for (i = 0; i < n_samples; i++) begin
      if (rand_fill) begin
        recv_msg[i] = sample_t'($random(seed));
      end else begin
        recv_msg[i] = sample_t'(test * 256 + blk * 16 + i);  // counting pattern.
      end
    end
  endtask

  // holds recv_val until the block is taken, returns 1 ns after that edge.
  task automatic offer_block(input test_row_t cur, input int test, input int blk);
    int waited;
    waited = 0;
    fill_block(cur.rand_fill, test, blk);
    recv_val = 1'b1;
    @(negedge clk);
    while (!recv_rdy) begin
      waited++;
      if (waited > wait_limit) begin
        $display("test %0d: block %0d was never accepted by the DUT", test, blk);
        tb_errors++;
        @(posedge clk);
        #1;
        recv_val = 1'b0;
        return;
      end
      @(posedge clk);
      #1;
      if (cur.poke) fill_block(1'b1, test, blk);
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_blocks_done(input int target, input int test);
    int waited;
    waited = 0;
    while (blocks_seen < target) begin
      waited++;
      if (waited > drain_limit) begin
        $display("test %0d: the DUT did not finish sending its blocks", test);
        tb_errors++;
        return;
      end
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    int total_blocks;
    int errors_before;
    int beats_before;
    int b;
    int t;
    seed         = 32'hc3e01904;
    reset        = 1'b1;
    recv_msg     = '0;
    recv_val     = 1'b0;
    send_rdy     = 1'b1;
    stall_mask   = 8'hff;
    cycle_no     = 0;
    tb_errors    = 0;
    total_blocks = 0;

    // blocks, random fill, stall mask, gap, poke.
    table_rows[0] = '{8'd1, 1'b0, 8'hff, 4'd2, 1'b0};  // first block after reset.
    table_rows[1] = '{8'd4, 1'b0, 8'hff, 4'd0, 1'b0};  // back to back.
    table_rows[2] = '{8'd3, 1'b1, 8'b1010_0110, 4'd1, 1'b0};
    table_rows[3] = '{8'd4, 1'b1, 8'b0001_0001, 4'd3, 1'b0};
    table_rows[4] = '{8'd3, 1'b1, 8'hff, 4'd0, 1'b1};
    table_rows[5] = '{8'd5, 1'b1, 8'b1101_1011, 4'd0, 1'b1};

    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    for (t = 0; t < n_tests; t++) begin
      row           = table_rows[t];
      errors_before = tb_errors + check_errors;
      beats_before  = beats_seen;
      stall_mask    = row.stall_mask;
      for (b = 0; b < row.blocks; b++) begin
        offer_block(row, t, b);
        if ((row.gap != 0) || (b == row.blocks - 1)) recv_val = 1'b0;
        repeat (row.gap) begin
          @(posedge clk);
          #1;
        end
      end
      total_blocks += row.blocks;
      wait_blocks_done(total_blocks, t);
      stall_mask = 8'hff;
      if (beats_seen - beats_before != row.blocks * n_samples) begin
        $display("CHECK FAILED t=%0t beat_count expected %0d got %0d", $time,
                 row.blocks * n_samples, beats_seen - beats_before);
        tb_errors++;
      end
      $display("test %0d done: %0d blocks, %0d beats, %0d errors", t, row.blocks,
               beats_seen - beats_before, tb_errors + check_errors - errors_before);
    end

    repeat (4) @(posedge clk);
    $display("summary: %0d tests, %0d blocks, %0d beats, %0d errors", n_tests,
             blocks_seen, beats_seen, tb_errors + check_errors);
    if (tb_errors + check_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* sources.f */
logic/serial_cfg_pkg.sv
logic/serial_types_pkg.sv
logic/serializer_control.sv
logic/sample_counter.sv
logic/sample_bank.sv
logic/block_serializer.sv
testbench/serializer_properties.sv
testbench/serializer_checker.sv
testbench/block_serializer_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the block serializer testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module block_serializer_tb \
  -Mdir obj_dir \
  -f sources.f
status=$?
if [ $status -ne 0 ]; then
  echo "compile step failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vblock_serializer_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q '^No errors$'; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
